// ==== Makefile ====
TOP := miniAluTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

# The run passes only when the pass line shows up in the output
sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | \
		awk '{ print } /^TESTS PASSED$$/ { found = 1 } END { exit !found }'

clean:
	rm -rf obj_dir

// ==== program.hex ====
// One 28-bit word per line: op, destination, source1, source0 (two hex digits each after op)
// STO reads the last four digits as one 16-bit immediate
// Register setup: r1=5, r2=3, r6=1, r7=4, r5=0
3010005
3020003
3060001
3070004
3050000
// r3 = r1 + r2, then show r3
4030102
1000300
// r4 = r1 - r2, then show r4
6040102
1000400
// Loop at 09: show r5, r5 = r5 + r6, back to 09 while r5 <= r7
1000500
4050506
2090507
// Undefined opcode 15 shows r1
F000100
// Park on a jump to itself at 0d
50D0000

// ==== sources.f ====
src/miniAluPkg.sv
src/instructionRom.sv
src/fetchUnit.sv
src/registerFile.sv
src/executeUnit.sv
src/miniAlu.sv
testbench/miniAlu_assertions.sv
testbench/miniAluTb.sv

// ==== src/executeUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeUnit
(
	input  logic                             Clock,
	input  logic                             reset,
	input  miniAluPkg::instruction_u         instruction,
	input  logic [miniAluPkg::dataWidth-1:0] operand0,
	input  logic [miniAluPkg::dataWidth-1:0] operand1,
	output miniAluPkg::regWrite_t            write,
	output miniAluPkg::branch_t              branch,
	output logic [7:0]                       led,
	output logic                             ledWrite
);

	logic ledLoad;

	// ------------------------------------------------------------------------
	// Decode and ALU
	// ------------------------------------------------------------------------
	always_comb
	begin
		ledLoad       = 1'b0;
		write.enable  = 1'b0;
		write.address = instruction.regView.destination[miniAluPkg::regAddrWidth-1:0];
		write.data    = '0;
		branch.taken  = 1'b0;
		branch.target = instruction.regView.destination; // Branch target is the destination

		case (instruction.regView.op)
		miniAluPkg::opNop:
		begin
			ledLoad = 1'b0;
		end

		miniAluPkg::opLed:
		begin
			ledLoad = 1'b1;
		end

		miniAluPkg::opBle:
		begin
			branch.taken = (operand1 <= operand0); // Unsigned compare
		end

		miniAluPkg::opSto:
		begin
			write.enable = 1'b1;
			write.data   = instruction.immView.immediate; // Sources read as one field
		end

		miniAluPkg::opAdd:
		begin
			write.enable = 1'b1;
			write.data   = operand1 + operand0;
		end

		miniAluPkg::opJmp:
		begin
			branch.taken = 1'b1;
		end

		miniAluPkg::opSub:
		begin
			write.enable = 1'b1;
			write.data   = operand1 - operand0; // Wraps modulo 2^16
		end

		default:
		begin
			ledLoad = 1'b1; // Unknown opcodes act as LED
		end
		endcase
	end

	// ------------------------------------------------------------------------
	// LED port
	// ------------------------------------------------------------------------
	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			led      <= '0;
			ledWrite <= 1'b0;
		end
		else
		begin
			ledWrite <= ledLoad; // Strobe follows the load by one cycle
			if (ledLoad)
				led <= operand1[7:0];
		end
	end

endmodule

`default_nettype wire

// ==== src/fetchUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchUnit
(
	input  logic                     Clock,
	input  logic                     reset,
	input  miniAluPkg::branch_t      branch,
	output miniAluPkg::instruction_u rawInstruction,
	output miniAluPkg::instruction_u instruction
);

	logic [miniAluPkg::ipWidth-1:0] instructionPointer;
	logic [miniAluPkg::ipWidth-1:0] fetchAddress;
	miniAluPkg::instruction_u       romWord;

	// ------------------------------------------------------------------------
	// Fetch address
	// ------------------------------------------------------------------------
	// A taken branch redirects the ROM in the same cycle, so the target word
	// is latched at the coming edge and no slot is lost
	assign fetchAddress = branch.taken ? branch.target : instructionPointer;

	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			instructionPointer <= '0;
		end
		else
		begin
			instructionPointer <= fetchAddress + 1'b1; // Wraps from 255 to 0
		end
	end

	instructionRom instructionRom_i
	(
		.address (fetchAddress),
		.data    (romWord)
	);

	// ------------------------------------------------------------------------
	// Decode register
	// ------------------------------------------------------------------------
	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			instruction <= '0; // Opcode zero is NOP
		end
		else
		begin
			instruction <= romWord;
		end
	end

	// Source fields of this word address the register file one cycle early
	assign rawInstruction = romWord;

endmodule

`default_nettype wire

// ==== src/instructionRom.sv ====
`timescale 1ns/100ps
`default_nettype none

module instructionRom
(
	input  logic [miniAluPkg::ipWidth-1:0] address,
	output miniAluPkg::instruction_u      data
);

	logic [miniAluPkg::instrWidth-1:0] memory [0:miniAluPkg::romDepth-1];

	// All-zero words decode as NOP, so the tail past the program is harmless
	initial
	begin
		for (int i = 0; i < miniAluPkg::romDepth; i++)
		begin
			memory[i] = '0;
		end
		$readmemh("program.hex", memory);
	end

	assign data = memory[address]; // Asynchronous read

endmodule

`default_nettype wire

// ==== src/miniAlu.sv ====
`timescale 1ns/100ps
`default_nettype none

module miniAlu
(
	input  logic       Clock,
	input  logic       reset,
	output logic [7:0] led,
	output logic       ledWrite
);

	miniAluPkg::instruction_u         rawInstruction;
	miniAluPkg::instruction_u         instruction;
	miniAluPkg::regWrite_t            write;
	miniAluPkg::branch_t              branch;
	logic [miniAluPkg::dataWidth-1:0] operand0;
	logic [miniAluPkg::dataWidth-1:0] operand1;

	fetchUnit fetchUnit_i
	(
		.Clock          (Clock),
		.reset          (reset),
		.branch         (branch),
		.rawInstruction (rawInstruction),
		.instruction    (instruction)
	);

	// Operands are addressed from the ROM word so they line up with decode
	registerFile registerFile_i
	(
		.Clock        (Clock),
		.reset        (reset),
		.readAddress0 (rawInstruction.regView.source0[miniAluPkg::regAddrWidth-1:0]),
		.readAddress1 (rawInstruction.regView.source1[miniAluPkg::regAddrWidth-1:0]),
		.write        (write),
		.operand0     (operand0),
		.operand1     (operand1)
	);

	executeUnit executeUnit_i
	(
		.Clock       (Clock),
		.reset       (reset),
		.instruction (instruction),
		.operand0    (operand0),
		.operand1    (operand1),
		.write       (write),
		.branch      (branch),
		.led         (led),
		.ledWrite    (ledWrite)
	);

endmodule

`default_nettype wire

// ==== src/miniAluPkg.sv ====
`default_nettype none

package miniAluPkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------
	localparam int dataWidth    = 16; // Registers and ALU results
	localparam int instrWidth   = 28; // One instruction word
	localparam int ipWidth      = 8;  // Instruction pointer and ROM address
	localparam int regAddrWidth = 4;  // Register file index bits in use
	localparam int romDepth     = 2 ** ipWidth;

	// ------------------------------------------------------------------------
	// Opcodes
	// ------------------------------------------------------------------------
	typedef enum logic [3:0]
	{
		opNop = 4'd0,
		opLed = 4'd1, // Show low byte of source 1
		opBle = 4'd2, // Branch if source 1 <= source 0
		opSto = 4'd3, // Load a 16-bit immediate
		opAdd = 4'd4,
		opJmp = 4'd5,
		opSub = 4'd6  // Source 1 minus source 0
	} opcode_t;

	// ------------------------------------------------------------------------
	// Instruction formats
	// ------------------------------------------------------------------------
	typedef struct packed
	{
		opcode_t    op;
		logic [7:0] destination;
		logic [7:0] source1;
		logic [7:0] source0;
	} regForm_t;

	// The immediate overlays both source fields, source1 in the upper byte
	typedef struct packed
	{
		opcode_t               op;
		logic [7:0]            destination;
		logic [dataWidth-1:0]  immediate;
	} immForm_t;

	typedef union packed
	{
		regForm_t regView; // ALU, branch and LED operations
		immForm_t immView; // STO only
	} instruction_u;

	// ------------------------------------------------------------------------
	// Unit-to-unit buses
	// ------------------------------------------------------------------------
	typedef struct packed
	{
		logic                    enable;
		logic [regAddrWidth-1:0] address;
		logic [dataWidth-1:0]    data;
	} regWrite_t;

	typedef struct packed
	{
		logic               taken;
		logic [ipWidth-1:0] target;
	} branch_t;

endpackage

`default_nettype wire

// ==== src/registerFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module registerFile
(
	input  logic                                Clock,
	input  logic                                reset,
	input  logic [miniAluPkg::regAddrWidth-1:0] readAddress0,
	input  logic [miniAluPkg::regAddrWidth-1:0] readAddress1,
	input  miniAluPkg::regWrite_t               write,
	output logic [miniAluPkg::dataWidth-1:0]    operand0,
	output logic [miniAluPkg::dataWidth-1:0]    operand1
);

	localparam int depth = 2 ** miniAluPkg::regAddrWidth;

	logic [miniAluPkg::dataWidth-1:0] registers [0:depth-1];

	// A read of the register being written sees the new value
	function automatic logic [miniAluPkg::dataWidth-1:0] readPort
	(
		input logic [miniAluPkg::regAddrWidth-1:0] address
	);
		if (write.enable && (write.address == address))
			return write.data;
		return registers[address];
	endfunction

	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < depth; i++)
			begin
				registers[i] <= '0;
			end
			operand0 <= '0;
			operand1 <= '0;
		end
		else
		begin
			if (write.enable)
				registers[write.address] <= write.data;
			operand0 <= readPort(readAddress0); // One cycle of read latency
			operand1 <= readPort(readAddress1);
		end
	end

endmodule

`default_nettype wire

// ==== testbench/miniAluTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module miniAluTb;

	localparam int clockPeriod = 100;
	localparam int resetCycles = 4;
	localparam int idleCycles  = 50; // Quiet window once the program parks
	localparam int stepCount   = 8;

	// One pass of the program with the idle window and the reset replay needs
	// about a hundred cycles, so this bound is generous and still finite
	localparam int runCycles     = 200;
	localparam int timeoutCycles = 2 * runCycles;

	typedef struct packed
	{
		logic [7:0] expected; // LED value seen with the strobe
		logic [2:0] test;     // Behavior the step belongs to
		logic       endsTest; // Last step of that behavior
	} ledStep_t;

	logic       Clock;
	logic       reset;
	logic [7:0] led;
	logic       ledWrite;

	ledStep_t    steps [0:stepCount-1];
	string       testNames [1:6];
	int          errorCount;
	int          testStartErrors;
	int          testsPassed;
	int          testsFailed;
	int unsigned cycleCount;
	int unsigned assertionFailures;
	logic [7:0]  heldLed;

	miniAlu dut_i
	(
		.Clock    (Clock),
		.reset    (reset),
		.led      (led),
		.ledWrite (ledWrite)
	);

	// ------------------------------------------------------------------------
	// Clock and run limit
	// ------------------------------------------------------------------------
	initial
	begin
		Clock = 1'b0;
		forever
		begin
			#(clockPeriod / 2) Clock = ~Clock;
		end
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles)
		begin
			@(posedge Clock);
			cycleCount++;
		end
		$display("timeout waiting for LED update");
		$display("TESTS FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	task automatic checkValue
	(
		input string      name,
		input logic [7:0] expected,
		input logic [7:0] actual
	);
		if (actual !== expected)
		begin
			$display("FAILED %s expected %h got %h", name, expected, actual);
			errorCount++;
		end
	endtask

	// Samples at the falling edge, where led and ledWrite are settled
	task automatic waitForLedPulse(input logic [7:0] holdValue);
		@(negedge Clock);
		while (!ledWrite)
		begin
			checkValue("led", holdValue, led); // No change without the strobe
			@(negedge Clock);
		end
	endtask

	task automatic finishTest(input int number);
		if (errorCount == testStartErrors)
		begin
			testsPassed++;
			$display("test %0d %s: pass", number, testNames[number]);
		end
		else
		begin
			testsFailed++;
			$display("test %0d %s: fail", number, testNames[number]);
		end
		testStartErrors = errorCount;
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial
	begin
		reset           = 1'b1;
		errorCount      = 0;
		testStartErrors = 0;
		testsPassed     = 0;
		testsFailed     = 0;
		heldLed         = 8'h00;

		steps[0] = '{8'h08, 3'd2, 1'b1}; // r1 + r2
		steps[1] = '{8'h02, 3'd3, 1'b1}; // r1 - r2
		steps[2] = '{8'h00, 3'd4, 1'b0}; // Loop passes with r5 counting up
		steps[3] = '{8'h01, 3'd4, 1'b0};
		steps[4] = '{8'h02, 3'd4, 1'b0};
		steps[5] = '{8'h03, 3'd4, 1'b0};
		steps[6] = '{8'h04, 3'd4, 1'b1};
		steps[7] = '{8'h05, 3'd5, 1'b0}; // Undefined opcode shows r1

		testNames[1] = "reset state";
		testNames[2] = "store, add and show";
		testNames[3] = "subtract order";
		testNames[4] = "branch loop";
		testNames[5] = "undefined opcode and halt";
		testNames[6] = "reset replay";

		repeat (resetCycles) @(posedge Clock);
		#1 reset = 1'b0;

		@(negedge Clock);
		checkValue("led", 8'h00, led);
		checkValue("ledWrite", 8'h00, 8'(ledWrite));
		waitForLedPulse(8'h00);
		finishTest(1);

		// Each pass checks the strobe already seen, then waits for the next one
		for (int i = 0; i < stepCount; i++)
		begin
			checkValue("led", steps[i].expected, led);
			heldLed = led;
			if (steps[i].endsTest)
				finishTest(int'(steps[i].test));
			if (i < stepCount - 1)
				waitForLedPulse(heldLed);
		end

		// The jump to itself must keep the port still
		repeat (idleCycles)
		begin
			@(negedge Clock);
			checkValue("ledWrite", 8'h00, 8'(ledWrite));
			checkValue("led", heldLed, led);
		end
		finishTest(5);

		@(posedge Clock);
		#1 reset = 1'b1;
		repeat (resetCycles) @(posedge Clock);
		#1 reset = 1'b0;
		@(negedge Clock);
		checkValue("led", 8'h00, led);
		checkValue("ledWrite", 8'h00, 8'(ledWrite));
		waitForLedPulse(8'h00);
		checkValue("led", 8'h08, led); // Program restarts from address 0
		finishTest(6);

		assertionFailures = dut_i.executeUnit_i.executeChecks_i.failures;
		$display("%0d tests passed, %0d tests failed, %0d assertion failures",
			testsPassed, testsFailed, assertionFailures);
		if ((testsFailed == 0) && (assertionFailures == 0))
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/miniAlu_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeUnitAssertions
(
	input logic                     Clock,
	input logic                     reset,
	input miniAluPkg::instruction_u instruction,
	input miniAluPkg::regWrite_t    write,
	input miniAluPkg::branch_t      branch,
	input logic                     ledWrite
);

	int unsigned failures = 0; // Read by the testbench at the end of the run

	// The strobe stays low through reset and the first cycle after release
	ledQuietAfterReset: assert property (
		@(posedge Clock) ($past(reset) || $past(reset, 2)) |-> !ledWrite
	)
	else
	begin
		failures++;
		$error("ledWrite high during reset or the cycle after it");
	end

	writeOrBranch: assert property (
		@(posedge Clock) disable iff (reset) !(write.enable && branch.taken)
	)
	else
	begin
		failures++;
		$error("register write and taken branch in the same cycle");
	end

	// The full destination field has to fit the sixteen registers
	writeInRange: assert property (
		@(posedge Clock) disable iff (reset)
			write.enable |-> (instruction.regView.destination < 8'd16)
	)
	else
	begin
		failures++;
		$error("register write to an address above 15");
	end

endmodule

bind executeUnit executeUnitAssertions executeChecks_i
(
	.Clock       (Clock),
	.reset       (reset),
	.instruction (instruction),
	.write       (write),
	.branch      (branch),
	.ledWrite    (ledWrite)
);

`default_nettype wire
